/* hw/recovery_pkg.sv */
`default_nettype none

package recovery_pkg;

  // Buffer and queue sizes
  localparam int unsigned RespBufDepth = 64;
  localparam int unsigned RespLenWidth = 16;
  localparam int unsigned TxFifoDepth  = 8;

  // SMBus PEC polynomial, x^8 + x^2 + x + 1
  localparam logic [7:0] PecPoly = 8'h07;

  // Response header handed from buffer to transmitter
  typedef struct packed {
    logic [RespLenWidth-1:0] len;
  } res_desc_t;

  // One response byte, last marks the end of the response
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } res_beat_t;

  // Transmitter frame states
  typedef enum logic [7:0] {
    Idle   = 8'h00,
    TxLenL = 8'h10,
    TxLenH = 8'h11,
    TxData = 8'h20,
    TxPec  = 8'h30,
    Flush  = 8'hF0
  } tx_state_e;

endpackage

`default_nettype wire

/* hw/recovery_pec.sv */
`timescale 1ns/1ps
`default_nettype none

module recovery_pec
  import recovery_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       init_i,
  input  wire logic       enable_i,
  input  wire logic [7:0] data_i,
  output logic      [7:0] crc_o
);

  logic [7:0] crc_q;
  logic [7:0] crc_next;

  // Fold one byte into the running CRC, MSB first
  always_comb begin
    crc_next = crc_q ^ data_i;
    for (int i = 0; i < 8; i++) begin
      if (crc_next[7]) begin
        crc_next = {crc_next[6:0], 1'b0} ^ PecPoly;
      end else begin
        crc_next = {crc_next[6:0], 1'b0};
      end
    end
  end

  // Init wins over enable
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      crc_q <= 8'h00;
    end else if (init_i) begin
      crc_q <= 8'h00;
    end else if (enable_i) begin
      crc_q <= crc_next;
    end
  end

  assign crc_o = crc_q;

endmodule

`default_nettype wire

/* hw/recovery_response_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module recovery_response_buffer
  import recovery_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_ni,

  // Firmware write port
  input  wire logic      wr_valid_i,
  output logic           wr_ready_o,
  input  wire res_beat_t wr_beat_i,

  // Response header
  output logic           res_valid_o,
  input  wire logic      res_ready_i,
  output res_desc_t      res_desc_o,

  // Response data
  output logic           res_dvalid_o,
  input  wire logic      res_dready_i,
  output res_beat_t      res_beat_o
);

  localparam int unsigned AddrW = $clog2(RespBufDepth);
  localparam int unsigned CntW  = $clog2(RespBufDepth + 1);

  logic [7:0]      mem_q [RespBufDepth];
  logic [CntW-1:0] wr_cnt_q;
  logic [AddrW-1:0] rd_idx_q;
  logic            full_q;
  logic            hdr_sent_q;
  logic            wr_fire;
  logic            wr_close;
  logic            rd_fire;
  logic            rd_last;

  // Writes only while no response is held and there is room left
  assign wr_ready_o = ~full_q & (wr_cnt_q < CntW'(RespBufDepth));
  assign wr_fire    = wr_valid_i & wr_ready_o;

  // Only a beat with last set closes the response
  assign wr_close = wr_fire & wr_beat_i.last;

  assign rd_last = (CntW'(rd_idx_q) == wr_cnt_q - CntW'(1));
  assign rd_fire = res_dvalid_o & res_dready_i;

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      mem_q[wr_cnt_q[AddrW-1:0]] <= wr_beat_i.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_cnt_q   <= '0;
      rd_idx_q   <= '0;
      full_q     <= 1'b0;
      hdr_sent_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        wr_cnt_q <= wr_cnt_q + CntW'(1);
      end
      if (wr_close) begin
        full_q <= 1'b1;
      end
      if (res_valid_o && res_ready_i) begin
        hdr_sent_q <= 1'b1;
      end
      if (rd_fire) begin
        if (rd_last) begin
          // Last byte gone so reopen for the next response
          wr_cnt_q   <= '0;
          rd_idx_q   <= '0;
          full_q     <= 1'b0;
          hdr_sent_q <= 1'b0;
        end else begin
          rd_idx_q <= rd_idx_q + AddrW'(1);
        end
      end
    end
  end

  // Header offered once per stored response
  assign res_valid_o    = full_q & ~hdr_sent_q;
  assign res_desc_o.len = RespLenWidth'(wr_cnt_q);

  // Data stays valid until the last beat is consumed
  assign res_dvalid_o    = full_q;
  assign res_beat_o.data = mem_q[rd_idx_q];
  assign res_beat_o.last = rd_last;

endmodule

`default_nettype wire

/* hw/recovery_transmitter.sv */
`timescale 1ns/1ps
`default_nettype none

module recovery_transmitter
  import recovery_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,

  // Response header
  input  wire logic       res_valid_i,
  output logic            res_ready_o,
  input  wire res_desc_t  res_desc_i,

  // Response data
  input  wire logic       res_dvalid_i,
  output logic            res_dready_o,
  input  wire res_beat_t  res_beat_i,

  input  wire logic       host_abort_i,

  // PEC control
  input  wire logic [7:0] pec_crc_i,
  output logic            pec_init_o,
  output logic            pec_enable_o,

  // Framed bytes toward the TX FIFO
  output logic            data_valid_o,
  input  wire logic       data_ready_i,
  output logic      [7:0] data_data_o
);

  tx_state_e               state_q;
  tx_state_e               state_d;
  logic [RespLenWidth-1:0] len_q;
  logic                    data_fire;

  assign data_fire = data_valid_o & data_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Abort in a length or data state always goes through Flush
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (res_valid_i) state_d = TxLenL;
      end
      TxLenL: begin
        if (host_abort_i) state_d = Flush;
        else if (data_fire) state_d = TxLenH;
      end
      TxLenH: begin
        if (host_abort_i) state_d = Flush;
        else if (data_fire) state_d = TxData;
      end
      TxData: begin
        if (host_abort_i) state_d = Flush;
        else if (data_fire && res_beat_i.last) state_d = TxPec;
      end
      TxPec: begin
        if (data_fire) state_d = Idle;
      end
      Flush: begin
        // Drain until the buffer has released the response
        if (!res_dvalid_i) state_d = Idle;
      end
      default: state_d = Idle;
    endcase
  end

  // Length is captured with the header
  always_ff @(posedge clk_i) begin
    if (res_valid_i && res_ready_o) begin
      len_q <= res_desc_i.len;
    end
  end

  assign res_ready_o = (state_q == Idle);
  assign pec_init_o  = res_valid_i & res_ready_o;

  always_comb begin
    unique case (state_q)
      TxData:  res_dready_o = data_ready_i & ~host_abort_i;
      Flush:   res_dready_o = 1'b1;
      default: res_dready_o = 1'b0;
    endcase
  end

  // No byte leaves on the cycle an abort is seen
  always_comb begin
    unique case (state_q)
      TxLenL:  data_valid_o = ~host_abort_i;
      TxLenH:  data_valid_o = ~host_abort_i;
      TxData:  data_valid_o = res_dvalid_i & ~host_abort_i;
      TxPec:   data_valid_o = 1'b1;
      default: data_valid_o = 1'b0;
    endcase
  end

  always_comb begin
    unique case (state_q)
      TxLenL:  data_data_o = len_q[7:0];
      TxLenH:  data_data_o = len_q[15:8];
      TxPec:   data_data_o = pec_crc_i;
      default: data_data_o = res_beat_i.data;
    endcase
  end

  // PEC covers length and data bytes only
  always_comb begin
    unique case (state_q)
      TxLenL, TxLenH, TxData: pec_enable_o = data_fire;
      default:                pec_enable_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/recovery_tx_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module recovery_tx_fifo
  import recovery_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,

  // Write side, from the transmitter
  input  wire logic       wvalid_i,
  output logic            wready_o,
  input  wire logic [7:0] wdata_i,

  // Read side, toward the bus
  output logic            rvalid_o,
  input  wire logic       rready_i,
  output logic      [7:0] rdata_o
);

  localparam int unsigned AddrW = $clog2(TxFifoDepth);
  localparam int unsigned CntW  = $clog2(TxFifoDepth + 1);

  logic [7:0]       mem_q [TxFifoDepth];
  logic [AddrW-1:0] wr_ptr_q;
  logic [AddrW-1:0] rd_ptr_q;
  logic [CntW-1:0]  cnt_q;
  logic             push;
  logic             pop;

  assign wready_o = (cnt_q != CntW'(TxFifoDepth));
  assign rvalid_o = (cnt_q != '0);
  assign push     = wvalid_i & wready_o;
  assign pop      = rvalid_o & rready_i;
  assign rdata_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + AddrW'(1);
      if (pop)  rd_ptr_q <= rd_ptr_q + AddrW'(1);
      // Simultaneous push and pop leaves the count unchanged
      if (push && !pop)      cnt_q <= cnt_q + CntW'(1);
      else if (pop && !push) cnt_q <= cnt_q - CntW'(1);
    end
  end

endmodule

`default_nettype wire

/* hw/recovery_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module recovery_tx_top
  import recovery_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,

  // Firmware write port
  input  wire logic       wr_valid_i,
  output logic            wr_ready_o,
  input  wire res_beat_t  wr_beat_i,

  input  wire logic       host_abort_i,

  // Bus side of the TX FIFO
  output logic            tx_valid_o,
  input  wire logic       tx_ready_i,
  output logic      [7:0] tx_data_o
);

  logic       res_valid;
  logic       res_ready;
  res_desc_t  res_desc;
  logic       res_dvalid;
  logic       res_dready;
  res_beat_t  res_beat;
  logic       pec_init;
  logic       pec_enable;
  logic [7:0] pec_crc;
  logic       tx_wvalid;
  logic       tx_wready;
  logic [7:0] tx_wdata;

  recovery_response_buffer u_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wr_valid_i   (wr_valid_i),
    .wr_ready_o   (wr_ready_o),
    .wr_beat_i    (wr_beat_i),
    .res_valid_o  (res_valid),
    .res_ready_i  (res_ready),
    .res_desc_o   (res_desc),
    .res_dvalid_o (res_dvalid),
    .res_dready_i (res_dready),
    .res_beat_o   (res_beat)
  );

  recovery_transmitter u_transmitter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .res_valid_i  (res_valid),
    .res_ready_o  (res_ready),
    .res_desc_i   (res_desc),
    .res_dvalid_i (res_dvalid),
    .res_dready_o (res_dready),
    .res_beat_i   (res_beat),
    .host_abort_i (host_abort_i),
    .pec_crc_i    (pec_crc),
    .pec_init_o   (pec_init),
    .pec_enable_o (pec_enable),
    .data_valid_o (tx_wvalid),
    .data_ready_i (tx_wready),
    .data_data_o  (tx_wdata)
  );

  // PEC sees the same byte that goes into the FIFO
  recovery_pec u_pec (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .init_i   (pec_init),
    .enable_i (pec_enable),
    .data_i   (tx_wdata),
    .crc_o    (pec_crc)
  );

  recovery_tx_fifo u_tx_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (tx_wvalid),
    .wready_o (tx_wready),
    .wdata_i  (tx_wdata),
    .rvalid_o (tx_valid_o),
    .rready_i (tx_ready_i),
    .rdata_o  (tx_data_o)
  );

endmodule

`default_nettype wire

/* sim/recovery_tx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module recovery_tx_tb
  import recovery_pkg::*;
();

  localparam int unsigned NumResp    = 43;
  localparam int unsigned NumRandom  = 20;
  localparam int unsigned DrainLimit = 2000;
  localparam logic [7:0]  RefPoly    = 8'h07;

  typedef logic [7:0] byte_q_t[$];

  logic       clk_i;
  logic       rst_ni;
  logic       wr_valid_i;
  logic       wr_ready_o;
  res_beat_t  wr_beat_i;
  logic       host_abort_i;
  logic       tx_valid_o;
  logic       tx_ready_i;
  logic [7:0] tx_data_o;

  byte_q_t     payload_all;
  int unsigned resp_len[$];
  int unsigned resp_off[$];
  int unsigned frame_bytes;
  byte_q_t     exp_q;
  byte_q_t     abort_q;
  byte_q_t     abort_frame;
  logic        capture_abort;
  logic        stall_en;
  logic        ready_level;
  integer      seed;
  int unsigned errors;
  int unsigned checks;

  recovery_tx_top uut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wr_valid_i   (wr_valid_i),
    .wr_ready_o   (wr_ready_o),
    .wr_beat_i    (wr_beat_i),
    .host_abort_i (host_abort_i),
    .tx_valid_o   (tx_valid_o),
    .tx_ready_i   (tx_ready_i),
    .tx_data_o    (tx_data_o)
  );

  always #50 clk_i = ~clk_i;

  // SMBus CRC-8, MSB first
  function automatic logic [7:0] crc8_update(input logic [7:0] crc, input logic [7:0] b);
    logic [7:0] c;
    c = crc ^ b;
    for (int i = 0; i < 8; i++) begin
      if (c[7]) begin
        c = {c[6:0], 1'b0} ^ RefPoly;
      end else begin
        c = {c[6:0], 1'b0};
      end
    end
    return c;
  endfunction

  // Length low, length high, data, then PEC over all of those
  function automatic byte_q_t frame_ref(input byte_q_t p);
    byte_q_t     f;
    logic [7:0]  crc;
    logic [15:0] len;
    len = 16'(p.size());
    f.push_back(len[7:0]);
    f.push_back(len[15:8]);
    foreach (p[i]) f.push_back(p[i]);
    crc = 8'h00;
    foreach (f[i]) crc = crc8_update(crc, f[i]);
    f.push_back(crc);
    return f;
  endfunction

  function automatic byte_q_t payload_of(input int unsigned r);
    byte_q_t p;
    for (int unsigned i = 0; i < resp_len[r]; i++) begin
      p.push_back(payload_all[resp_off[r] + i]);
    end
    return p;
  endfunction

  task automatic check_eq(input logic [7:0] actual, input logic [7:0] expected,
                          input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0t ns: %s, got 0x%h, expected 0x%h", $time, what, actual, expected);
    end
  endtask

  // Lengths 5, 1 and 64 first, 40 for the aborted frame, the rest random
  task automatic build_stimulus();
    int unsigned off;
    off = 0;
    frame_bytes = 0;
    for (int unsigned r = 0; r < NumResp; r++) begin
      if (r == 0) resp_len.push_back(5);
      else if (r == 1) resp_len.push_back(1);
      else if (r == 2) resp_len.push_back(RespBufDepth);
      else if (r == NumResp - 2) resp_len.push_back(40);
      else resp_len.push_back(($unsigned($random(seed)) % RespBufDepth) + 1);
      resp_off.push_back(off);
      for (int unsigned i = 0; i < resp_len[r]; i++) begin
        payload_all.push_back(8'($random(seed)));
      end
      off += resp_len[r];
      frame_bytes += resp_len[r] + 3;
    end
  endtask

  task automatic write_beat(input logic [7:0] d, input logic last);
    wr_valid_i     = 1'b1;
    wr_beat_i.data = d;
    wr_beat_i.last = last;
    @(negedge clk_i);
    while (!wr_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    wr_valid_i = 1'b0;
    wr_beat_i  = '0;
  endtask

  task automatic send_response(input int unsigned r, input logic expect_frame);
    byte_q_t p;
    byte_q_t f;
    p = payload_of(r);
    f = frame_ref(p);
    if (expect_frame) begin
      foreach (f[i]) exp_q.push_back(f[i]);
    end
    foreach (p[i]) write_beat(p[i], i == p.size() - 1);
  endtask

  task automatic wait_drained();
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while ((exp_q.size() != 0 || tx_valid_o) && n < DrainLimit) begin
      n++;
      @(negedge clk_i);
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Frame bytes never sent: %0d still expected at %0t ns", exp_q.size(), $time);
      exp_q.delete();
    end
    @(posedge clk_i);
    #1;
  endtask

  // Bus side ready, random when stalling is on
  initial begin : ready_driver
    logic stall_now;
    logic level_now;
    tx_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      stall_now = stall_en;
      level_now = ready_level;
      #1;
      tx_ready_i = stall_now ? 1'($random(seed)) : level_now;
    end
  end

  initial begin : monitor
    logic [7:0]  expected;
    int unsigned rx_count;
    rx_count = 0;
    forever begin
      @(negedge clk_i);
      if (rst_ni && tx_valid_o && tx_ready_i) begin
        if (capture_abort) begin
          abort_q.push_back(tx_data_o);
        end else if (exp_q.size() == 0) begin
          errors++;
          $display("Unexpected byte 0x%h on the bus at %0t ns", tx_data_o, $time);
        end else begin
          expected = exp_q.pop_front();
          check_eq(tx_data_o, expected, $sformatf("bus byte %0d", rx_count));
        end
        rx_count++;
      end
    end
  end

  initial begin : watchdog
    #1;
    repeat (frame_bytes * 200 + 1000) @(posedge clk_i);
    $display("Timeout: run still busy after %0d cycles, errors so far %0d",
             frame_bytes * 200 + 1000, errors);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : stimulus
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    wr_valid_i    = 1'b0;
    wr_beat_i     = '0;
    host_abort_i  = 1'b0;
    seed          = 5;
    errors        = 0;
    checks        = 0;
    capture_abort = 1'b0;
    stall_en      = 1'b0;
    ready_level   = 1'b1;
    build_stimulus();
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Quiet after reset
    repeat (10) begin
      @(negedge clk_i);
      check_eq(8'(tx_valid_o), 8'h00, "tx_valid_o after reset");
      check_eq(8'(wr_ready_o), 8'h01, "wr_ready_o after reset");
    end
    @(posedge clk_i);
    #1;

    send_response(0, 1'b1);
    wait_drained();
    for (int unsigned r = 1; r <= NumRandom; r++) send_response(r, 1'b1);
    wait_drained();

    // Same traffic with bus stalls
    stall_en = 1'b1;
    for (int unsigned r = NumRandom + 1; r < NumResp - 2; r++) send_response(r, 1'b1);
    wait_drained();
    stall_en = 1'b0;

    // Abort while the FIFO is backed up
    ready_level   = 1'b0;
    capture_abort = 1'b1;
    send_response(NumResp - 2, 1'b0);
    repeat (20) @(posedge clk_i);
    #1;
    host_abort_i = 1'b1;
    @(negedge clk_i);
    while (!wr_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    host_abort_i = 1'b0;
    ready_level  = 1'b1;
    repeat (3) @(negedge clk_i);
    while (tx_valid_o) begin
      @(negedge clk_i);
    end
    repeat (10) @(negedge clk_i);
    abort_frame = frame_ref(payload_of(NumResp - 2));
    if (abort_q.size() > TxFifoDepth) begin
      errors++;
      $display("Aborted frame sent %0d bytes, more than the FIFO holds", abort_q.size());
    end
    foreach (abort_q[i]) check_eq(abort_q[i], abort_frame[i], "aborted frame prefix");
    @(posedge clk_i);
    #1;
    capture_abort = 1'b0;

    send_response(NumResp - 1, 1'b1);
    wait_drained();
    repeat (20) @(negedge clk_i);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
hw/recovery_pkg.sv
hw/recovery_pec.sv
hw/recovery_response_buffer.sv
hw/recovery_transmitter.sv
hw/recovery_tx_fifo.sv
hw/recovery_tx_top.sv
sim/recovery_tx_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := recovery_tx_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
